// ==== Bender.yml ====
package:
  name: psram_uart

sources:
  - files:
      - hw/psram_pkg.sv
      - hw/apb_if.sv
      - hw/uart_rx.sv
      - hw/uart_cmd_decoder.sv
      - hw/sync_fifo.sv
      - hw/apb_bus_master.sv
      - hw/psram_async_ctrl.sv
      - hw/uart_resp_tx.sv
      - hw/psram_uart_top.sv
  - target: test
    files:
      - dv/psram_uart_checker.sv
      - dv/tb_psram_uart.sv

// ==== dv/psram_uart_checker.sv ====
`timescale 1ns/1ns

module psram_uart_checker import psram_pkg::*; (
  input logic              clk50MHz,
  input logic              rst_n,
  input logic              psel,
  input logic              penable,
  input logic              pwrite,
  input logic [ADDR_W-1:0] paddr,
  input logic              pready,
  input logic              mce_L,
  input logic              moe_L,
  input logic              mwe_L
);

  // The PSRAM must never see a write and an output enable at once.
  a_we_oe_excl: assert property (@(posedge clk50MHz) disable iff (!rst_n)
    !(!mwe_L && !moe_L))
    else $error("mwe_L and moe_L are low in the same cycle");

  a_pready_in_access: assert property (@(posedge clk50MHz) disable iff (!rst_n)
    pready |-> (psel && penable))
    else $error("pready is high outside an APB access phase");

  a_access_stable: assert property (@(posedge clk50MHz) disable iff (!rst_n)
    (psel && penable && !pready) |=> ($stable(paddr) && $stable(pwrite)))
    else $error("paddr or pwrite changed while the access phase waited for pready");

  a_reset_ce: assert property (@(posedge clk50MHz) !rst_n |=> mce_L)
    else $error("mce_L is low during reset");

endmodule

bind psram_async_ctrl psram_uart_checker chk0 (
  .clk50MHz(clk50MHz), .rst_n(rst_n), .psel(apb.psel), .penable(apb.penable),
  .pwrite(apb.pwrite), .paddr(apb.paddr), .pready(apb.pready),
  .mce_L(mce_L), .moe_L(moe_L), .mwe_L(mwe_L));

// ==== dv/tb_psram_uart.sv ====
`timescale 1ns/1ns

module tb_psram_uart import psram_pkg::*; ();
  localparam int CLKS_PER_BIT = 8;
  localparam int WAIT_LIMIT   = 2000; // Cycles allowed while waiting for a start bit.

  logic              clk50MHz;
  logic              rst_n;
  logic              rx;
  logic              mwait;
  logic              tx;
  wire  [DATA_W-1:0] mem_data;
  logic [ADDR_W-1:0] maddr;
  logic              mce_L, moe_L, mwe_L, mub_L, mlb_L, madv_L, mclk, mcre;

  int                errors;
  int                checks;
  bit                timed_out;
  logic [DATA_W-1:0] mem_model [logic [ADDR_W-1:0]];
  logic [DATA_W-1:0] sb [logic [ADDR_W-1:0]];
  logic              wr_pending;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_word;
  logic [DATA_W-1:0] rd_word;

  psram_uart_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut0 (
    .clk50MHz(clk50MHz), .rst_n(rst_n), .rx(rx), .tx(tx), .mem_data(mem_data),
    .maddr(maddr), .mce_L(mce_L), .moe_L(moe_L), .mwe_L(mwe_L), .mub_L(mub_L),
    .mlb_L(mlb_L), .madv_L(madv_L), .mclk(mclk), .mcre(mcre), .mwait(mwait));

  initial begin
    clk50MHz = 1'b0;
    forever #2 clk50MHz = ~clk50MHz;
  end

  // Behavioral PSRAM. Write data is taken during the strobe window and stored when mwe_L rises.
  always @(negedge clk50MHz) begin
    if (!mce_L && !mwe_L) begin
      wr_pending <= 1'b1;
      wr_addr    <= maddr;
      wr_word    <= mem_data;
    end
    if (!mce_L) rd_word <= mem_model.exists(maddr) ? mem_model[maddr] : 16'hFFFF;
  end

  always @(posedge mwe_L) begin
    if (wr_pending) begin
      mem_model[wr_addr] = wr_word;
      wr_pending <= 1'b0;
    end
  end

  assign mem_data = (!mce_L && !moe_L) ? rd_word : 16'hzzzz;

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk50MHz);
    #1;
  endtask

  task automatic check_value(input logic [15:0] got, input logic [15:0] expected,
                             input string what);
    if (timed_out) return;
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("Error at %0t ns: %s was %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    wait_clocks(1); // Every rx change lands just after a rising edge.
    frame = {1'b1, b, 1'b0}; // Start bit goes out first, then LSB first.
    for (int i = 0; i < 10; i++) begin
      rx = frame[i];
      wait_clocks(CLKS_PER_BIT);
    end
  endtask

  task automatic recv_byte(output logic [7:0] b);
    int waited;
    b = 8'h00;
    waited = 0;
    if (timed_out) return;
    @(negedge clk50MHz);
    while (tx !== 1'b0 && waited < WAIT_LIMIT) begin
      @(negedge clk50MHz);
      waited++;
    end
    if (tx !== 1'b0) begin
      $display("Timeout at %0t ns: no start bit on tx within %0d cycles", $time, WAIT_LIMIT);
      timed_out = 1'b1;
    end else begin
      repeat (CLKS_PER_BIT / 2) @(negedge clk50MHz); // Middle of the start bit.
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk50MHz);
        b[i] = tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk50MHz);
      check_value(16'(tx), 16'h0001, "stop bit on tx");
    end
  endtask

  task automatic send_write(input logic [22:0] addr, input logic [15:0] data);
    send_byte(8'h57);
    send_byte({1'b0, addr[22:16]});
    send_byte(addr[15:8]);
    send_byte(addr[7:0]);
    send_byte(data[15:8]);
    send_byte(data[7:0]);
  endtask

  task automatic send_read(input logic [22:0] addr);
    send_byte(8'h52);
    send_byte({1'b0, addr[22:16]});
    send_byte(addr[15:8]);
    send_byte(addr[7:0]);
  endtask

  function automatic logic [15:0] expected_word(input logic [22:0] addr);
    return sb.exists(addr) ? sb[addr] : 16'hFFFF;
  endfunction

  // Word that the PSRAM model holds at exactly this address.
  function automatic logic [15:0] stored_word(input logic [22:0] addr);
    return mem_model.exists(addr) ? mem_model[addr] : 16'hFFFF;
  endfunction

  task automatic write_word(input logic [22:0] addr, input logic [15:0] data);
    logic [7:0] reply;
    fork
      send_write(addr, data);
      recv_byte(reply);
    join
    check_value(16'(reply), 16'h004B, "write reply");
    sb[addr] = data;
  endtask

  task automatic read_word(input logic [22:0] addr, input logic [15:0] expected);
    logic [7:0] hi;
    logic [7:0] lo;
    fork
      send_read(addr);
      begin
        recv_byte(hi);
        recv_byte(lo);
      end
    join
    check_value({hi, lo}, expected, "read data");
  endtask

  task automatic test_idle();
    for (int i = 0; i < 100; i++) begin
      @(negedge clk50MHz);
      check_value(16'({tx, mce_L, mwe_L, moe_L, mub_L, mlb_L, madv_L, mclk, mcre}), 16'h01F8,
                  "idle tx and PSRAM pins");
      check_value(mem_data, 16'hzzzz, "idle mem_data");
    end
    wait_clocks(1);
  endtask

  task automatic test_write_read();
    logic [22:0] addr;
    logic [15:0] data;
    addr = 23'($urandom());
    data = 16'($urandom());
    write_word(addr, data);
    read_word(addr, data);
  endtask

  task automatic test_unread();
    logic [22:0] addr;
    do addr = 23'($urandom()); while (sb.exists(addr));
    read_word(addr, 16'hFFFF);
  endtask

  task automatic test_back_to_back();
    logic [22:0] addrs [4];
    logic [15:0] datas [4];
    logic [7:0]  replies [8];
    for (int i = 0; i < 4; i++) begin
      addrs[i] = 23'($urandom());
      datas[i] = 16'($urandom());
    end
    fork
      for (int i = 0; i < 4; i++) send_write(addrs[i], datas[i]);
      for (int i = 0; i < 4; i++) recv_byte(replies[i]);
    join
    for (int i = 0; i < 4; i++) begin
      check_value(16'(replies[i]), 16'h004B, "queued write reply");
      sb[addrs[i]] = datas[i];
    end
    fork
      for (int i = 0; i < 4; i++) send_read(addrs[i]);
      for (int i = 0; i < 8; i++) recv_byte(replies[i]);
    join
    for (int i = 0; i < 4; i++)
      check_value({replies[2*i], replies[2*i+1]}, expected_word(addrs[i]), "queued read data");
  endtask

  task automatic test_unknown_opcode();
    logic [22:0] addr;
    logic [7:0]  hi;
    logic [7:0]  lo;
    addr = 23'($urandom());
    write_word(addr, 16'($urandom()));
    fork
      begin
        send_byte(8'hA5); // Not an opcode, so the decoder stays idle.
        send_read(addr);
      end
      begin
        recv_byte(hi);
        recv_byte(lo);
      end
    join
    check_value({hi, lo}, expected_word(addr), "read after unknown opcode");
  endtask

  task automatic test_addr_width();
    logic [15:0] data;
    data = 16'($urandom());
    write_word(23'h000000, data);
    write_word(23'h7FFFFF, ~data);
    // Each maddr bit is low for one write and high for the other.
    check_value(stored_word(23'h000000), data, "PSRAM word at address 0");
    check_value(stored_word(23'h7FFFFF), ~data, "PSRAM word at the top address");
    read_word(23'h000000, data);
    read_word(23'h7FFFFF, ~data);
  endtask

  initial begin
    rst_n      = 1'b0;
    rx         = 1'b1;
    mwait      = 1'b0;
    errors     = 0;
    checks     = 0;
    timed_out  = 1'b0;
    wr_pending = 1'b0;
    void'($urandom(32'heaa6));
    repeat (5) @(posedge clk50MHz);
    #1 rst_n = 1'b1;
    test_idle();
    test_write_read();
    test_unread();
    test_back_to_back();
    test_unknown_opcode();
    test_addr_width();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/apb_bus_master.sv ====
`timescale 1ns/1ns

module apb_bus_master import psram_pkg::*; (
  input  logic      clk50MHz,
  input  logic      rst_n,
  input  mem_req_t  req_data,
  input  logic      req_empty,
  output logic      req_pop,
  apb_if.master     apb,
  output logic      resp_push,
  output mem_resp_t resp_data,
  input  logic      resp_full
);
  typedef enum logic [1:0] {S_IDLE, S_SETUP, S_ACCESS} state_t;

  state_t state;

  // A new request is taken only when its response is sure to find room.
  assign req_pop   = (state == S_IDLE) && !req_empty && !resp_full;
  assign resp_push = (state == S_ACCESS) && apb.pready;

  assign resp_data.is_read = !apb.pwrite;
  assign resp_data.rdata   = apb.pwrite ? '0 : apb.prdata;

  always_ff @(posedge clk50MHz) begin
    if (!rst_n) begin
      state       <= S_IDLE;
      apb.psel    <= 1'b0;
      apb.penable <= 1'b0;
    end else begin
      case (state)
        S_IDLE: if (req_pop) begin
          apb.psel   <= 1'b1;
          apb.pwrite <= req_data.is_write;
          apb.paddr  <= req_data.addr;
          apb.pwdata <= req_data.wdata;
          state      <= S_SETUP;
        end
        S_SETUP: begin
          apb.penable <= 1'b1;
          state       <= S_ACCESS;
        end
        S_ACCESS: if (apb.pready) begin
          apb.psel    <= 1'b0;
          apb.penable <= 1'b0;
          state       <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/apb_if.sv ====
`timescale 1ns/1ns

interface apb_if #(
  parameter int AW = 23,
  parameter int DW = 16
);
  logic          psel;
  logic          penable;
  logic          pwrite;
  logic [AW-1:0] paddr;
  logic [DW-1:0] pwdata;
  logic [DW-1:0] prdata;
  logic          pready;

  modport master (output psel, penable, pwrite, paddr, pwdata, input prdata, pready);
  modport slave  (input psel, penable, pwrite, paddr, pwdata, output prdata, pready);
endinterface

// ==== hw/psram_async_ctrl.sv ====
`timescale 1ns/1ns

module psram_async_ctrl import psram_pkg::*; #(
  parameter int ACCESS_CYCLES = 4
) (
  input  logic              clk50MHz,
  input  logic              rst_n,
  apb_if.slave              apb,
  inout  wire  [DATA_W-1:0] mem_data,
  output logic [ADDR_W-1:0] maddr,
  output logic              mce_L,
  output logic              moe_L,
  output logic              mwe_L,
  output logic              mub_L,
  output logic              mlb_L,
  output logic              madv_L,
  output logic              mclk,
  output logic              mcre,
  input  logic              mwait
);
  localparam int CNT_W = $clog2(ACCESS_CYCLES + 1);

  logic              active; // Strobe window is open.
  logic              wr_q;
  logic              drive_q;
  logic [CNT_W-1:0]  cnt;
  logic [DATA_W-1:0] wdata_q;
  logic [DATA_W-1:0] rdata_q;

  // Asynchronous mode only, so mwait carries no information here.
  assign madv_L = 1'b0;
  assign mclk   = 1'b0;
  assign mcre   = 1'b0;

  assign mce_L = !active;
  assign mwe_L = !(active && wr_q);
  assign moe_L = !(active && !wr_q);
  assign mub_L = mce_L; // Both bytes are always enabled.
  assign mlb_L = mce_L;

  // Write data stays on the bus one cycle past mwe_L for hold time.
  assign mem_data   = drive_q ? wdata_q : 'z;
  assign apb.prdata = rdata_q;

  always_ff @(posedge clk50MHz) begin
    if (!rst_n) begin
      active     <= 1'b0;
      drive_q    <= 1'b0;
      cnt        <= '0;
      apb.pready <= 1'b0;
    end else begin
      apb.pready <= 1'b0;
      if (apb.pready) drive_q <= 1'b0;
      if (apb.psel && !apb.penable && !active) begin
        active  <= 1'b1;
        cnt     <= '0;
        wr_q    <= apb.pwrite;
        drive_q <= apb.pwrite;
        maddr   <= apb.paddr;
        wdata_q <= apb.pwdata;
      end else if (active) begin
        cnt <= cnt + 1'b1;
        if (cnt == CNT_W'(ACCESS_CYCLES - 1)) begin
          active     <= 1'b0;
          apb.pready <= 1'b1;
          if (!wr_q) rdata_q <= mem_data; // Sampled before moe_L rises.
        end
      end
    end
  end

endmodule

// ==== hw/psram_pkg.sv ====
package psram_pkg;

  localparam int ADDR_W = 23; // Word address into the PSRAM.
  localparam int DATA_W = 16;

  localparam logic [7:0] OP_WRITE = 8'h57;
  localparam logic [7:0] OP_READ  = 8'h52;
  localparam logic [7:0] RESP_ACK = 8'h4B;

  // One memory request as built from a UART frame.
  typedef struct packed {
    logic              is_write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  // Read data travels back with its flag, a write only needs the flag.
  typedef struct packed {
    logic              is_read;
    logic [DATA_W-1:0] rdata;
  } mem_resp_t;

endpackage

// ==== hw/psram_uart_top.sv ====
`timescale 1ns/1ns

module psram_uart_top import psram_pkg::*; #(
  parameter int CLKS_PER_BIT  = 434,
  parameter int FIFO_DEPTH    = 4,
  parameter int ACCESS_CYCLES = 4
) (
  input  logic              clk50MHz,
  input  logic              rst_n,
  input  logic              rx,
  output logic              tx,
  inout  wire  [DATA_W-1:0] mem_data,
  output logic [ADDR_W-1:0] maddr,
  output logic              mce_L,
  output logic              moe_L,
  output logic              mwe_L,
  output logic              mub_L,
  output logic              mlb_L,
  output logic              madv_L,
  output logic              mclk,
  output logic              mcre,
  input  logic              mwait
);
  logic [7:0] rx_byte;
  logic       rx_valid;
  logic       req_push, req_full, req_pop, req_empty;
  logic       resp_push, resp_full, resp_pop, resp_empty;
  mem_req_t   req_wdata, req_rdata;
  mem_resp_t  resp_wdata, resp_rdata;

  apb_if #(.AW(ADDR_W), .DW(DATA_W)) apb ();

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .clk50MHz(clk50MHz), .rst_n(rst_n), .rx(rx),
    .byte_data(rx_byte), .byte_valid(rx_valid));

  uart_cmd_decoder u_dec (
    .clk50MHz(clk50MHz), .rst_n(rst_n), .byte_data(rx_byte), .byte_valid(rx_valid),
    .req_push(req_push), .req_data(req_wdata), .req_full(req_full));

  sync_fifo #(.payload_t(mem_req_t), .FIFO_DEPTH(FIFO_DEPTH)) u_req_fifo (
    .clk50MHz(clk50MHz), .rst_n(rst_n), .push(req_push), .wdata(req_wdata),
    .full(req_full), .pop(req_pop), .rdata(req_rdata), .empty(req_empty));

  apb_bus_master u_master (
    .clk50MHz(clk50MHz), .rst_n(rst_n), .req_data(req_rdata), .req_empty(req_empty),
    .req_pop(req_pop), .apb(apb.master), .resp_push(resp_push),
    .resp_data(resp_wdata), .resp_full(resp_full));

  psram_async_ctrl #(.ACCESS_CYCLES(ACCESS_CYCLES)) u_psram (
    .clk50MHz(clk50MHz), .rst_n(rst_n), .apb(apb.slave), .mem_data(mem_data),
    .maddr(maddr), .mce_L(mce_L), .moe_L(moe_L), .mwe_L(mwe_L), .mub_L(mub_L),
    .mlb_L(mlb_L), .madv_L(madv_L), .mclk(mclk), .mcre(mcre), .mwait(mwait));

  sync_fifo #(.payload_t(mem_resp_t), .FIFO_DEPTH(FIFO_DEPTH)) u_resp_fifo (
    .clk50MHz(clk50MHz), .rst_n(rst_n), .push(resp_push), .wdata(resp_wdata),
    .full(resp_full), .pop(resp_pop), .rdata(resp_rdata), .empty(resp_empty));

  uart_resp_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .clk50MHz(clk50MHz), .rst_n(rst_n), .resp_data(resp_rdata),
    .resp_empty(resp_empty), .resp_pop(resp_pop), .tx(tx));

endmodule

// ==== hw/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo import psram_pkg::*; #(
  parameter type payload_t  = mem_req_t,
  parameter int  FIFO_DEPTH = 4
) (
  input  logic     clk50MHz,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t wdata,
  output logic     full,
  input  logic     pop,
  output payload_t rdata,
  output logic     empty
);
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);

  payload_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign rdata   = mem[rd_ptr]; // Head is visible before the pop.

  always_ff @(posedge clk50MHz) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk50MHz) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

endmodule

// ==== hw/uart_cmd_decoder.sv ====
`timescale 1ns/1ns

module uart_cmd_decoder import psram_pkg::*; (
  input  logic       clk50MHz,
  input  logic       rst_n,
  input  logic [7:0] byte_data,
  input  logic       byte_valid,
  output logic       req_push,
  output mem_req_t   req_data,
  input  logic       req_full
);
  typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA, S_PUSH} state_t;

  state_t     state;
  logic [1:0] byte_cnt;

  // While the FIFO is full the request waits here and new bytes are dropped.
  assign req_push = (state == S_PUSH) && !req_full;

  always_ff @(posedge clk50MHz) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      byte_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: if (byte_valid) begin
          byte_cnt          <= '0;
          req_data.is_write <= (byte_data == OP_WRITE);
          req_data.wdata    <= '0;
          if (byte_data == OP_WRITE || byte_data == OP_READ) state <= S_ADDR;
        end
        S_ADDR: if (byte_valid) begin
          req_data.addr <= {req_data.addr[ADDR_W-9:0], byte_data}; // MSB first.
          byte_cnt      <= byte_cnt + 1'b1;
          if (byte_cnt == 2'd2) begin
            byte_cnt <= '0;
            state    <= req_data.is_write ? S_DATA : S_PUSH;
          end
        end
        S_DATA: if (byte_valid) begin
          req_data.wdata <= {req_data.wdata[7:0], byte_data};
          byte_cnt       <= byte_cnt + 1'b1;
          if (byte_cnt == 2'd1) state <= S_PUSH;
        end
        S_PUSH: if (!req_full) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/uart_resp_tx.sv ====
`timescale 1ns/1ns

module uart_resp_tx import psram_pkg::*; #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic      clk50MHz,
  input  logic      rst_n,
  input  mem_resp_t resp_data,
  input  logic      resp_empty,
  output logic      resp_pop,
  output logic      tx
);
  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  logic             busy;
  logic             second_pend;
  logic [7:0]       second_byte;
  logic [9:0]       frame; // Stop, data and start bits, sent from bit 0.
  logic [3:0]       bit_idx;
  logic [CNT_W-1:0] cnt;

  assign resp_pop = !busy && !resp_empty;
  assign tx       = frame[0];

  always_ff @(posedge clk50MHz) begin
    if (!rst_n) begin
      busy        <= 1'b0;
      second_pend <= 1'b0;
      frame       <= '1;
      bit_idx     <= '0;
      cnt         <= '0;
    end else if (resp_pop) begin
      busy        <= 1'b1;
      cnt         <= '0;
      bit_idx     <= '0;
      second_pend <= resp_data.is_read;
      second_byte <= resp_data.rdata[7:0];
      frame <= {1'b1, resp_data.is_read ? resp_data.rdata[15:8] : RESP_ACK, 1'b0};
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      if (cnt == CLKS_PER_BIT - 1) begin
        cnt     <= '0;
        frame   <= {1'b1, frame[9:1]};
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == 4'd9) begin
          bit_idx <= '0;
          if (second_pend) begin
            second_pend <= 1'b0;
            frame       <= {1'b1, second_byte, 1'b0};
          end else begin
            busy <= 1'b0;
          end
        end
      end
    end
  end

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx import psram_pkg::*; #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clk50MHz,
  input  logic       rst_n,
  input  logic       rx,
  output logic [7:0] byte_data,
  output logic       byte_valid
);
  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

  state_t           state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [1:0]       rx_sync;

  always_ff @(posedge clk50MHz) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      cnt        <= '0;
      bit_idx    <= '0;
      rx_sync    <= 2'b11;
      byte_valid <= 1'b0;
    end else begin
      rx_sync    <= {rx_sync[0], rx};
      byte_valid <= 1'b0;
      cnt        <= cnt + 1'b1;
      case (state)
        S_IDLE: begin
          cnt <= '0;
          if (!rx_sync[1]) state <= S_START;
        end
        S_START: if (cnt == CLKS_PER_BIT / 2 - 1) begin // Middle of the start bit.
          cnt     <= '0;
          bit_idx <= '0;
          state   <= rx_sync[1] ? S_IDLE : S_DATA;
        end
        S_DATA: if (cnt == CLKS_PER_BIT - 1) begin
          cnt       <= '0;
          byte_data <= {rx_sync[1], byte_data[7:1]}; // LSB arrives first.
          bit_idx   <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) state <= S_STOP;
        end
        S_STOP: if (cnt == CLKS_PER_BIT - 1) begin
          // A low stop bit means a broken frame, so nothing is reported.
          byte_valid <= rx_sync[1];
          state      <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== sources.f ====
hw/psram_pkg.sv
hw/apb_if.sv
hw/uart_rx.sv
hw/uart_cmd_decoder.sv
hw/sync_fifo.sv
hw/apb_bus_master.sv
hw/psram_async_ctrl.sv
hw/uart_resp_tx.sv
hw/psram_uart_top.sv
dv/psram_uart_checker.sv
dv/tb_psram_uart.sv
